/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // a block is two words, so bit 2 picks the word
    localparam int addr_width       = 16;
    localparam int block_addr_width = addr_width - 3;
    localparam int word_width       = 32;
    localparam int block_width      = 2 * word_width;
    localparam int mem_tag_width    = 4;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    typedef logic [addr_width-1:0]       addr_t;
    typedef logic [block_addr_width-1:0] block_addr_t;
    typedef logic [word_width-1:0]       word_t;

    // word 0 sits in the low half
    typedef logic [block_width-1:0]      block_t;
    typedef logic [word_width/8-1:0]     byte_mask_t;

    // tag 0 means no transaction
    typedef logic [mem_tag_width-1:0]    mem_tag_t;

    ////////////////////////////////////////////////////////////
    // opcodes and states
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        op_load,
        op_store
    } req_op_e;

    typedef enum logic [1:0] {
        miss_idle,
        miss_issue,
        miss_wait,
        miss_fill
    } miss_state_e;

endpackage

`default_nettype wire

/* hw/dcache_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_array #(
    parameter int num_sets = 8
) (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire dcache_pkg::addr_t       lookup_addr,
    input  wire logic                    touch,
    input  wire logic                    store_hit,
    input  wire logic                    fill_valid,
    input  wire dcache_pkg::addr_t       fill_addr,
    input  wire logic                    fill_dirty,
    output logic                         hit,
    output logic                         hit_way,
    output logic                         victim_way,
    output logic                         victim_valid,
    output logic                         victim_dirty,
    output dcache_pkg::block_addr_t      victim_addr
);

    localparam int set_bits = $clog2(num_sets);

    logic [1:0]              valid [num_sets];
    logic [1:0]              dirty [num_sets];
    dcache_pkg::block_addr_t blk   [num_sets][2];

    // one bit per set naming the way to replace next
    logic [num_sets-1:0]     lru;

    logic [set_bits-1:0]     lookup_set;
    logic [set_bits-1:0]     fill_set;
    dcache_pkg::block_addr_t lookup_blk;

    assign lookup_set = lookup_addr[3 +: set_bits];
    assign lookup_blk = lookup_addr[15:3];
    assign fill_set   = fill_addr[3 +: set_bits];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (valid[lookup_set][w] && blk[lookup_set][w] == lookup_blk) begin
                hit     = 1'b1;
                hit_way = 1'(w);
            end
        end
    end

    // the block that a fill to this set pushes out
    assign victim_way   = lru[fill_set];
    assign victim_valid = valid[fill_set][victim_way];
    assign victim_dirty = dirty[fill_set][victim_way];
    assign victim_addr  = blk[fill_set][victim_way];

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= 2'b00;
                dirty[s] <= 2'b00;
            end
            lru <= '0;
        end else if (fill_valid) begin
            valid[fill_set][victim_way] <= 1'b1;
            dirty[fill_set][victim_way] <= fill_dirty;
            lru[fill_set]               <= ~victim_way;
        end else if (touch) begin
            // the way just used becomes most recent
            lru[lookup_set] <= ~hit_way;
            if (store_hit) begin
                dirty[lookup_set][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            blk[fill_set][victim_way] <= fill_addr[15:3];
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_data_array #(
    parameter int num_sets = 8
) (
    input  wire logic                        clock,
    input  wire logic [$clog2(num_sets)-1:0] set_idx,
    input  wire logic                        way,
    input  wire logic                        word_write,
    input  wire logic                        word_sel,
    input  wire dcache_pkg::word_t           word_data,
    input  wire dcache_pkg::byte_mask_t      byte_mask,
    input  wire logic                        block_write,
    input  wire dcache_pkg::block_t          block_data,
    output dcache_pkg::block_t               block_out
);

    dcache_pkg::block_t mem [num_sets][2];
    dcache_pkg::block_t merged;

    assign block_out = mem[set_idx][way];

    // store bytes laid over the current block
    always_comb begin
        merged = block_out;
        for (int b = 0; b < 4; b++) begin
            if (byte_mask[b]) begin
                merged[32 * word_sel + 8 * b +: 8] = word_data[8 * b +: 8];
            end
        end
    end

    // a fill replaces the whole block
    always_ff @(posedge clock) begin
        if (block_write) begin
            mem[set_idx][way] <= block_data;
        end else if (word_write) begin
            mem[set_idx][way] <= merged;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_miss_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_miss_unit (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   miss,
    input  wire dcache_pkg::addr_t      miss_addr,
    input  wire dcache_pkg::req_op_e    miss_op,
    input  wire dcache_pkg::word_t      miss_data,
    input  wire dcache_pkg::byte_mask_t miss_mask,
    input  wire logic                   fill_stall,
    input  wire logic                   mem_read_accepted,
    input  wire dcache_pkg::mem_tag_t   mem_req_tag,
    input  wire dcache_pkg::mem_tag_t   mem_resp_tag,
    input  wire dcache_pkg::block_t     mem_resp_data,
    output logic                        read_valid,
    output dcache_pkg::block_addr_t     read_addr,
    output logic                        fill_valid,
    output dcache_pkg::addr_t           fill_addr,
    output dcache_pkg::block_t          fill_data,
    output logic                        fill_dirty
);

    dcache_pkg::miss_state_e state;
    dcache_pkg::req_op_e     op_q;
    dcache_pkg::word_t       data_q;
    dcache_pkg::byte_mask_t  mask_q;
    dcache_pkg::mem_tag_t    tag_q;
    dcache_pkg::block_t      merged;
    logic                    resp_match;

    assign read_valid = state == dcache_pkg::miss_issue;
    assign read_addr  = fill_addr[15:3];
    assign fill_valid = state == dcache_pkg::miss_fill && !fill_stall;
    assign fill_dirty = op_q == dcache_pkg::op_store;
    assign resp_match = mem_resp_tag == tag_q;

    // a store miss writes its bytes into the returning block
    always_comb begin
        merged = mem_resp_data;
        for (int b = 0; b < 4; b++) begin
            if (fill_dirty && mask_q[b]) begin
                merged[32 * fill_addr[2] + 8 * b +: 8] = data_q[8 * b +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dcache_pkg::miss_idle;
        end else begin
            case (state)
                dcache_pkg::miss_idle:  if (miss) state <= dcache_pkg::miss_issue;
                dcache_pkg::miss_issue: if (mem_read_accepted) state <= dcache_pkg::miss_wait;
                dcache_pkg::miss_wait:  if (resp_match) state <= dcache_pkg::miss_fill;
                dcache_pkg::miss_fill:  if (!fill_stall) state <= dcache_pkg::miss_idle;
                default:                state <= dcache_pkg::miss_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::miss_idle && miss) begin
            fill_addr <= miss_addr;
            op_q      <= miss_op;
            data_q    <= miss_data;
            mask_q    <= miss_mask;
        end
        // tag the memory hands back for this read
        if (read_valid && mem_read_accepted) begin
            tag_q <= mem_req_tag;
        end
        if (state == dcache_pkg::miss_wait && resp_match) begin
            fill_data <= merged;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_wb_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_wb_buffer #(
    parameter int wb_depth = 4
) (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    push,
    input  wire dcache_pkg::block_addr_t push_addr,
    input  wire dcache_pkg::block_t      push_data,
    input  wire dcache_pkg::addr_t       lookup_addr,
    input  wire logic                    store_en,
    input  wire dcache_pkg::word_t       store_data,
    input  wire dcache_pkg::byte_mask_t  store_mask,
    input  wire logic                    drain_accepted,
    output logic                         wb_full,
    output logic                         hit,
    output dcache_pkg::block_t           hit_data,
    output logic                         drain_valid,
    output dcache_pkg::block_addr_t      drain_addr,
    output dcache_pkg::block_t           drain_data
);

    localparam int idx_bits = $clog2(wb_depth);

    logic [wb_depth-1:0]     valid;
    dcache_pkg::block_addr_t addr [wb_depth];
    dcache_pkg::block_t      data [wb_depth];
    logic [idx_bits-1:0]     head;
    logic [idx_bits-1:0]     tail;
    logic [idx_bits-1:0]     hit_idx;
    dcache_pkg::block_t      merged;
    logic                    store_hit;

    function automatic logic [idx_bits-1:0] next_ptr(input logic [idx_bits-1:0] ptr);
        return (ptr == idx_bits'(wb_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // address search
    ////////////////////////////////////////////////////////////

    // an evicted block is never cached again while it sits here,
    // so at most one entry matches
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < wb_depth; i++) begin
            if (valid[i] && addr[i] == lookup_addr[15:3]) begin
                hit     = 1'b1;
                hit_idx = idx_bits'(i);
            end
        end
    end

    assign hit_data  = data[hit_idx];
    assign store_hit = store_en && hit;

    always_comb begin
        merged = hit_data;
        for (int b = 0; b < 4; b++) begin
            if (store_mask[b]) begin
                merged[32 * lookup_addr[2] + 8 * b +: 8] = store_data[8 * b +: 8];
            end
        end
    end

    // head offered to memory, with a store in this same cycle folded in
    assign wb_full     = valid[tail];
    assign drain_valid = valid[head];
    assign drain_addr  = addr[head];
    assign drain_data  = (store_hit && hit_idx == head) ? merged : data[head];

    ////////////////////////////////////////////////////////////
    // FIFO update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (push) begin
                valid[tail] <= 1'b1;
                tail        <= next_ptr(tail);
            end
            if (drain_valid && drain_accepted) begin
                valid[head] <= 1'b0;
                head        <= next_ptr(head);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            addr[tail] <= push_addr;
            data[tail] <= push_data;
        end
        if (store_hit) begin
            data[hit_idx] <= merged;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int num_sets = 8,
    parameter int wb_depth = 4
) (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // load/store unit
    input  wire logic                    req_valid,
    input  wire dcache_pkg::req_op_e     req_op,
    input  wire dcache_pkg::addr_t       req_addr,
    input  wire dcache_pkg::word_t       req_data,
    input  wire dcache_pkg::byte_mask_t  req_byte_mask,
    output logic                         req_ready,
    output logic                         resp_valid,
    output dcache_pkg::word_t            resp_data,
    // memory
    output logic                         mem_req_valid,
    output logic                         mem_req_write,
    output dcache_pkg::block_addr_t      mem_req_addr,
    output dcache_pkg::block_t           mem_req_data,
    input  wire logic                    mem_req_accepted,
    input  wire dcache_pkg::mem_tag_t    mem_req_tag,
    input  wire dcache_pkg::mem_tag_t    mem_resp_tag,
    input  wire dcache_pkg::block_t      mem_resp_data
);

    localparam int set_bits = $clog2(num_sets);

    logic                    tag_hit;
    logic                    tag_hit_way;
    logic                    victim_way;
    logic                    victim_valid;
    logic                    victim_dirty;
    dcache_pkg::block_addr_t victim_addr;
    logic                    wb_hit;
    dcache_pkg::block_t      wb_hit_data;
    logic                    wb_full;
    logic                    drain_valid;
    dcache_pkg::block_addr_t drain_addr;
    dcache_pkg::block_t      drain_data;
    logic                    read_valid;
    dcache_pkg::block_addr_t read_addr;
    logic                    fill_valid;
    dcache_pkg::addr_t       fill_addr;
    dcache_pkg::block_t      fill_data;
    logic                    fill_dirty;
    dcache_pkg::block_t      block_out;
    dcache_pkg::block_t      hit_block;
    logic                    cache_take;
    logic                    is_store;
    logic                    fill_stall;
    logic                    evict_push;

    ////////////////////////////////////////////////////////////
    // request steering
    ////////////////////////////////////////////////////////////

    // write-back buffer first, then the cache, otherwise a miss
    assign is_store   = req_op == dcache_pkg::op_store;
    assign cache_take = req_valid && tag_hit && !wb_hit;
    assign req_ready  = req_valid && (wb_hit || tag_hit);

    // a dirty victim needs a free buffer slot before the fill can land
    assign evict_push = fill_valid && victim_valid && victim_dirty;
    assign fill_stall = wb_full && victim_valid && victim_dirty;

    dcache_tag_array #(.num_sets(num_sets)) tags (
        .clock        (clock),
        .reset        (reset),
        .lookup_addr  (req_addr),
        .touch        (cache_take),
        .store_hit    (cache_take && is_store),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_dirty   (fill_dirty),
        .hit          (tag_hit),
        .hit_way      (tag_hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    // on fill the read port shows the victim block for the push
    dcache_data_array #(.num_sets(num_sets)) data (
        .clock       (clock),
        .set_idx     (fill_valid ? fill_addr[3 +: set_bits] : req_addr[3 +: set_bits]),
        .way         (fill_valid ? victim_way : tag_hit_way),
        .word_write  (cache_take && is_store),
        .word_sel    (req_addr[2]),
        .word_data   (req_data),
        .byte_mask   (req_byte_mask),
        .block_write (fill_valid),
        .block_data  (fill_data),
        .block_out   (block_out)
    );

    dcache_miss_unit miss_unit (
        .clock             (clock),
        .reset             (reset),
        .miss              (req_valid && !wb_hit && !tag_hit),
        .miss_addr         (req_addr),
        .miss_op           (req_op),
        .miss_data         (req_data),
        .miss_mask         (req_byte_mask),
        .fill_stall        (fill_stall),
        .mem_read_accepted (read_valid && mem_req_accepted),
        .mem_req_tag       (mem_req_tag),
        .mem_resp_tag      (mem_resp_tag),
        .mem_resp_data     (mem_resp_data),
        .read_valid        (read_valid),
        .read_addr         (read_addr),
        .fill_valid        (fill_valid),
        .fill_addr         (fill_addr),
        .fill_data         (fill_data),
        .fill_dirty        (fill_dirty)
    );

    dcache_wb_buffer #(.wb_depth(wb_depth)) wb_buffer (
        .clock          (clock),
        .reset          (reset),
        .push           (evict_push),
        .push_addr      (victim_addr),
        .push_data      (block_out),
        .lookup_addr    (req_addr),
        .store_en       (req_valid && is_store),
        .store_data     (req_data),
        .store_mask     (req_byte_mask),
        .drain_accepted (!read_valid && mem_req_accepted),
        .wb_full        (wb_full),
        .hit            (wb_hit),
        .hit_data       (wb_hit_data),
        .drain_valid    (drain_valid),
        .drain_addr     (drain_addr),
        .drain_data     (drain_data)
    );

    ////////////////////////////////////////////////////////////
    // load response one cycle after the handshake
    ////////////////////////////////////////////////////////////

    assign hit_block = wb_hit ? wb_hit_data : block_out;

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_ready && !is_store;
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= req_addr[2] ? hit_block[63:32] : hit_block[31:0];
    end

    ////////////////////////////////////////////////////////////
    // memory arbitration
    ////////////////////////////////////////////////////////////

    // the miss read goes ahead of any drain
    assign mem_req_valid = read_valid || drain_valid;
    assign mem_req_write = !read_valid;
    assign mem_req_addr  = read_valid ? read_addr : drain_addr;
    assign mem_req_data  = drain_data;

endmodule

`default_nettype wire

/* verif/dcache_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_model (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    mem_req_valid,
    input  wire logic                    mem_req_write,
    input  wire dcache_pkg::block_addr_t mem_req_addr,
    input  wire dcache_pkg::block_t      mem_req_data,
    output logic                         mem_req_accepted,
    output dcache_pkg::mem_tag_t         mem_req_tag,
    output dcache_pkg::mem_tag_t         mem_resp_tag,
    output dcache_pkg::block_t           mem_resp_data
);

    logic [7:0]         bytes     [65536];
    logic               busy      [16];
    int                 wait_left [16];
    dcache_pkg::block_t read_data [16];
    logic               accept_roll;

    // only offered requests are ever accepted
    assign mem_req_accepted = mem_req_valid && accept_roll;

    ////////////////////////////////////////////////////////////
    // request side sampled on the rising edge
    ////////////////////////////////////////////////////////////

    initial begin
        for (int a = 0; a < 65536; a++) begin
            bytes[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
        end
        for (int t = 0; t < 16; t++) begin
            busy[t]      = 1'b0;
            wait_left[t] = 0;
        end
        forever begin
            @(posedge clock);
            if (reset) begin
                for (int t = 0; t < 16; t++) begin
                    busy[t] = 1'b0;
                end
            end else begin
                if (mem_resp_tag != '0) begin
                    busy[mem_resp_tag] = 1'b0;
                end
                for (int t = 1; t < 16; t++) begin
                    if (busy[t] && wait_left[t] > 0) begin
                        wait_left[t] = wait_left[t] - 1;
                    end
                end
                if (mem_req_accepted && mem_req_write) begin
                    for (int i = 0; i < 8; i++) begin
                        bytes[{mem_req_addr, 3'(i)}] = mem_req_data[8 * i +: 8];
                    end
                end else if (mem_req_accepted) begin
                    // read data is taken at acceptance and returned 3 to 12 cycles later
                    busy[mem_req_tag]      = 1'b1;
                    wait_left[mem_req_tag] = $urandom_range(2, 11);
                    for (int i = 0; i < 8; i++) begin
                        read_data[mem_req_tag][8 * i +: 8] = bytes[{mem_req_addr, 3'(i)}];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // acceptance and responses driven on the falling edge
    ////////////////////////////////////////////////////////////

    initial begin
        int   start;
        int   t;
        logic found;
        logic sent;
        accept_roll   <= 1'b0;
        mem_req_tag   <= 4'd1;
        mem_resp_tag  <= '0;
        mem_resp_data <= '0;
        forever begin
            @(negedge clock);
            found = 1'b0;
            start = $urandom_range(0, 14);
            for (int k = 0; k < 15; k++) begin
                t = 1 + (start + k) % 15;
                if (!found && !busy[t]) begin
                    found       = 1'b1;
                    mem_req_tag <= dcache_pkg::mem_tag_t'(t);
                end
            end
            accept_roll <= found && ($urandom_range(0, 99) < 70);
            sent = 1'b0;
            mem_resp_tag <= '0;
            for (int r = 1; r < 16; r++) begin
                if (!sent && busy[r] && wait_left[r] == 0) begin
                    sent          = 1'b1;
                    mem_resp_tag  <= dcache_pkg::mem_tag_t'(r);
                    mem_resp_data <= read_data[r];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/dcache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

    localparam int          num_ops        = 2000;
    localparam int          max_op_cycles  = 60;
    localparam int          timeout_cycles = num_ops * max_op_cycles;
    localparam int          reset_cycles   = 8;
    localparam logic [15:0] window_base    = 16'h2400;

    logic                    clock;
    logic                    reset;
    logic                    req_valid;
    dcache_pkg::req_op_e     req_op;
    dcache_pkg::addr_t       req_addr;
    dcache_pkg::word_t       req_data;
    dcache_pkg::byte_mask_t  req_byte_mask;
    logic                    req_ready;
    logic                    resp_valid;
    dcache_pkg::word_t       resp_data;
    logic                    mem_req_valid;
    logic                    mem_req_write;
    dcache_pkg::block_addr_t mem_req_addr;
    dcache_pkg::block_t      mem_req_data;
    logic                    mem_req_accepted;
    dcache_pkg::mem_tag_t    mem_req_tag;
    dcache_pkg::mem_tag_t    mem_resp_tag;
    dcache_pkg::block_t      mem_resp_data;

    // reference model of memory, plus which words were ever stored
    logic [7:0]        ref_mem [65536];
    logic              written [16384];
    int                errors;
    int                loads;
    int                stores;
    int                responses;
    int                ops_done;
    int                cycle_count = 0;
    logic              resp_due;
    dcache_pkg::word_t resp_expected;
    string             resp_name;

    dcache_top #(.num_sets(8), .wb_depth(4)) uut (.*);

    dcache_mem_model mem_model (.*);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d operations done",
                     cycle_count, ops_done, num_ops);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t addr);
        dcache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8 * b +: 8] = ref_mem[{addr[15:2], 2'(b)}];
        end
        return w;
    endfunction

    task automatic drive_random_op();
        int offset;
        offset        = $urandom_range(0, 127);
        req_valid     = 1'b1;
        req_op        = ($urandom_range(0, 1) == 0) ? dcache_pkg::op_load : dcache_pkg::op_store;
        req_addr      = window_base + dcache_pkg::addr_t'(offset * 4);
        req_data      = $urandom();
        req_byte_mask = dcache_pkg::byte_mask_t'($urandom_range(1, 15));
    endtask

    // resp_valid must match exactly the load handshake of the cycle before
    task automatic check_response();
        if (resp_valid) begin
            responses++;
            if (!resp_due) begin
                errors++;
                $display("load response seen with no load handshake one cycle earlier");
            end else begin
                check_value(resp_name, resp_expected, resp_data);
            end
        end else if (resp_due) begin
            errors++;
            $display("load response missing one cycle after the handshake");
        end
        resp_due = 1'b0;
    endtask

    task automatic record_handshake();
        if (req_op == dcache_pkg::op_store) begin
            stores++;
            for (int b = 0; b < 4; b++) begin
                if (req_byte_mask[b]) begin
                    ref_mem[{req_addr[15:2], 2'(b)}] = req_data[8 * b +: 8];
                end
            end
            written[req_addr[15:2]] = 1'b1;
        end else begin
            loads++;
            resp_due      = 1'b1;
            resp_expected = expected_word(req_addr);
            resp_name     = written[req_addr[15:2]] ? "stored_load" : "cold_load";
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic need_new;
        void'($urandom(32'hbb6c_1c83));
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
        end
        for (int w = 0; w < 16384; w++) begin
            written[w] = 1'b0;
        end
        errors        = 0;
        loads         = 0;
        stores        = 0;
        responses     = 0;
        ops_done      = 0;
        resp_due      = 1'b0;
        resp_expected = '0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_op        = dcache_pkg::op_load;
        req_addr      = window_base;
        req_data      = '0;
        req_byte_mask = '0;

        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        #1;
        check_value("reset_req_ready", 32'd0, 32'(req_ready));
        check_value("reset_resp_valid", 32'd0, 32'(resp_valid));
        check_value("reset_mem_req_valid", 32'd0, 32'(mem_req_valid));

        // requests are held until ready, with random idle gaps between them
        need_new = 1'b1;
        while (ops_done < num_ops) begin
            @(negedge clock);
            if (need_new && $urandom_range(0, 3) == 0) begin
                req_valid = 1'b0;
            end else if (need_new) begin
                drive_random_op();
            end
            #1;
            check_response();
            if (req_valid && req_ready) begin
                record_handshake();
                ops_done++;
                need_new = 1'b1;
            end else begin
                need_new = !req_valid;
            end
        end

        repeat (4) begin
            @(negedge clock);
            req_valid = 1'b0;
            #1;
            check_response();
        end

        check_value("resp_count", loads, responses);
        $display("done: %0d loads, %0d stores, %0d responses, %0d errors",
                 loads, stores, responses, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache.f */
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_miss_unit.sv
hw/dcache_wb_buffer.sv
hw/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module dcache_tb \
    -f dcache.f \
    -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
